// ==== hw/memory_game_pkg.sv ====
`default_nettype none

package memory_game_pkg;

    localparam int NUM_TILES    = 16;
    localparam int NUM_IMAGES   = 8;
    localparam int TILE_W       = 160;
    localparam int TILE_H       = 120;
    localparam int PAIRS_TO_WIN = 8;
    localparam int DEBOUNCE_LEN = 7;

    // 640x480 at one pixel per clk
    localparam int H_ACTIVE = 640;
    localparam int H_FRONT  = 16;
    localparam int H_SYNC   = 96;
    localparam int H_TOTAL  = 800;
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_TOTAL  = 525;

    typedef logic [3:0]  tile_idx_t;
    typedef logic [11:0] rgb_t;
    typedef logic [7:0]  scan_code_t;

    typedef enum logic [1:0] {
        INIT   = 2'd0,
        SHOW   = 2'd1,
        GAME   = 2'd2,
        FINISH = 2'd3
    } game_state_t;

    // Keys 1 2 3 4 / Q W E R / A S D F / Z X C V
    localparam scan_code_t TILE_KEYS [NUM_TILES] = '{
        8'h16, 8'h1E, 8'h26, 8'h25,
        8'h15, 8'h1D, 8'h24, 8'h2D,
        8'h1C, 8'h1B, 8'h23, 8'h2B,
        8'h1A, 8'h22, 8'h21, 8'h2A
    };

    localparam scan_code_t KEY_SHIFT = 8'h12;
    localparam scan_code_t KEY_ENTER = 8'h5A;

    // One flat colour per image, red in the top nibble
    localparam rgb_t PALETTE [NUM_IMAGES] = '{
        12'hF00, 12'h0F0, 12'h00F, 12'hFF0,
        12'h0FF, 12'hF0F, 12'hF80, 12'h8CF
    };

    localparam logic [NUM_TILES-1:0] INIT_FLIP_MASK = 16'h000D;

endpackage

`default_nettype wire

// ==== hw/button_pulse.sv ====
`timescale 1ns/1ps
`default_nettype none

module button_pulse import memory_game_pkg::*; #(
    parameter int DEBOUNCE_LEN = memory_game_pkg::DEBOUNCE_LEN
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  btn_i,
    output logic press_o
);

    logic [DEBOUNCE_LEN-1:0] samples;
    logic                    level;
    logic                    level_q;

    // Pressed only once every sample in the window is high
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            level_q <= 1'b0;
            press_o <= 1'b0;
        end else begin
            samples <= {samples[DEBOUNCE_LEN-2:0], btn_i};
            level_q <= level;
            press_o <= level && !level_q;
        end
    end

endmodule

`default_nettype wire

// ==== hw/key_receiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_receiver import memory_game_pkg::*; (
    input  wire             clk,
    input  wire             rst,
    input  wire             req_i,
    input  wire scan_code_t code_i,
    output logic            ack_o,
    output logic            tile_evt_o,
    output tile_idx_t       tile_o,
    output logic            shift_evt_o,
    output logic            enter_evt_o
);

    logic      req_s;
    logic      take;
    logic      hit_tile;
    tile_idx_t hit_idx;

    // New request seen and not yet answered
    assign take = req_s && !ack_o;

    always_comb begin
        hit_tile = 1'b0;
        hit_idx  = '0;
        for (int i = 0; i < NUM_TILES; i++) begin
            if (code_i == TILE_KEYS[i]) begin
                hit_tile = 1'b1;
                hit_idx  = tile_idx_t'(i);
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            req_s       <= 1'b0;
            ack_o       <= 1'b0;
            tile_evt_o  <= 1'b0;
            shift_evt_o <= 1'b0;
            enter_evt_o <= 1'b0;
        end else begin
            req_s       <= req_i;
            ack_o       <= req_s;
            tile_evt_o  <= take && hit_tile;
            shift_evt_o <= take && (code_i == KEY_SHIFT);
            enter_evt_o <= take && (code_i == KEY_ENTER);
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            tile_o <= hit_idx;
        end
    end

endmodule

`default_nettype wire

// ==== hw/game_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_control import memory_game_pkg::*; (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  start_i,
    input  wire                  hint_i,
    input  wire                  tile_evt_i,
    input  wire tile_idx_t       tile_i,
    input  wire                  shift_evt_i,
    input  wire                  enter_evt_i,
    input  wire [NUM_TILES-1:0]  flip_i,
    input  wire [NUM_TILES-1:0]  matched_i,
    output logic                 tile_reset_o,
    output logic                 reveal_all_o,
    output logic                 hide_unmatched_o,
    output logic [NUM_TILES-1:0] reveal_o,
    output logic [NUM_TILES-1:0] toggle_flip_o,
    output logic [NUM_TILES-1:0] set_matched_o,
    output logic                 pass_o
);

    game_state_t state;
    game_state_t state_nxt;
    logic        pend_valid;
    tile_idx_t   pend_tile;
    logic        shift_armed;
    logic [3:0]  match_cnt;

    logic play_tile;
    logic first_key;
    logic second_key;
    logic pair_match;

    assign play_tile  = (state == GAME) && tile_evt_i;
    assign first_key  = play_tile && !shift_armed && !pend_valid;
    assign second_key = play_tile && !shift_armed && pend_valid;

    // Same image, same orientation, both still open
    assign pair_match = (tile_i != pend_tile)
                     && ((tile_i % NUM_IMAGES) == (pend_tile % NUM_IMAGES))
                     && (flip_i[tile_i] == flip_i[pend_tile])
                     && !matched_i[tile_i] && !matched_i[pend_tile];

    assign pass_o = (state == FINISH);

    always_comb begin
        state_nxt = state;
        case (state)
            INIT:    if (start_i) state_nxt = SHOW;
            SHOW:    if (start_i) state_nxt = GAME;
            GAME:    if (match_cnt == 4'(PAIRS_TO_WIN)) state_nxt = FINISH;
            FINISH:  if (start_i) state_nxt = INIT;
            default: state_nxt = INIT;
        endcase
    end

    always_comb begin
        // Leaving SHOW resets the tiles, which hides them all
        tile_reset_o     = (state == INIT) || ((state == SHOW) && start_i);
        reveal_all_o     = (state == SHOW) || (state == FINISH) || ((state == GAME) && hint_i);
        hide_unmatched_o = (state == GAME) && enter_evt_i;
        reveal_o         = '0;
        toggle_flip_o    = '0;
        set_matched_o    = '0;
        if (play_tile) begin
            reveal_o[tile_i] = 1'b1;
        end
        if (play_tile && shift_armed) begin
            toggle_flip_o[tile_i] = 1'b1;
        end
        if (second_key && pair_match) begin
            set_matched_o[tile_i]    = 1'b1;
            set_matched_o[pend_tile] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state       <= INIT;
            pend_valid  <= 1'b0;
            shift_armed <= 1'b0;
            match_cnt   <= '0;
        end else begin
            state <= state_nxt;
            if (state != GAME) begin
                pend_valid  <= 1'b0;
                shift_armed <= 1'b0;
                match_cnt   <= '0;
            end else begin
                if (shift_evt_i) begin
                    shift_armed <= 1'b1;
                end else if (play_tile) begin
                    shift_armed <= 1'b0;
                end
                if (first_key) begin
                    pend_valid <= 1'b1;
                end else if (second_key) begin
                    pend_valid <= 1'b0;
                end
                if (second_key && pair_match) begin
                    match_cnt <= match_cnt + 4'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (first_key) begin
            pend_tile <= tile_i;
        end
    end

endmodule

`default_nettype wire

// ==== hw/tile_cell.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_cell import memory_game_pkg::*; #(
    parameter int TILE_ID = 0
) (
    input  wire  clk,
    input  wire  rst,
    input  wire  tile_reset_i,
    input  wire  reveal_all_i,
    input  wire  hide_unmatched_i,
    input  wire  reveal_i,
    input  wire  toggle_flip_i,
    input  wire  set_matched_i,
    output logic flip_o,
    output logic matched_o,
    output rgb_t color_o
);

    logic shown;

    // Tiles i and i+8 share an image
    assign color_o = shown ? PALETTE[TILE_ID % NUM_IMAGES] : '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            shown     <= 1'b0;
            flip_o    <= INIT_FLIP_MASK[TILE_ID];
            matched_o <= 1'b0;
        end else if (tile_reset_i) begin
            shown     <= 1'b0;
            flip_o    <= INIT_FLIP_MASK[TILE_ID];
            matched_o <= 1'b0;
        end else begin
            if (toggle_flip_i) begin
                flip_o <= !flip_o;
            end
            if (set_matched_i) begin
                matched_o <= 1'b1;
            end
            if (reveal_all_i || reveal_i) begin
                shown <= 1'b1;
            end else if (hide_unmatched_i && !matched_o) begin
                shown <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/vga_timing.sv ====
`timescale 1ns/1ps
`default_nettype none

module vga_timing import memory_game_pkg::*; #(
    parameter int H_ACTIVE = memory_game_pkg::H_ACTIVE,
    parameter int H_FRONT  = memory_game_pkg::H_FRONT,
    parameter int H_SYNC   = memory_game_pkg::H_SYNC,
    parameter int H_TOTAL  = memory_game_pkg::H_TOTAL,
    parameter int V_ACTIVE = memory_game_pkg::V_ACTIVE,
    parameter int V_FRONT  = memory_game_pkg::V_FRONT,
    parameter int V_SYNC   = memory_game_pkg::V_SYNC,
    parameter int V_TOTAL  = memory_game_pkg::V_TOTAL
) (
    input  wire        clk,
    input  wire        rst,
    output logic [9:0] h_cnt_o,
    output logic [9:0] v_cnt_o,
    output logic       active_o,
    output logic       hsync_o,
    output logic       vsync_o
);

    logic line_end;

    assign line_end = (h_cnt_o == 10'(H_TOTAL - 1));
    assign active_o = (h_cnt_o < 10'(H_ACTIVE)) && (v_cnt_o < 10'(V_ACTIVE));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            h_cnt_o <= '0;
            v_cnt_o <= '0;
        end else begin
            h_cnt_o <= line_end ? 10'd0 : h_cnt_o + 10'd1;
            if (line_end) begin
                v_cnt_o <= (v_cnt_o == 10'(V_TOTAL - 1)) ? 10'd0 : v_cnt_o + 10'd1;
            end
        end
    end

    // Syncs lag the counters by one cycle
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hsync_o <= 1'b1;
            vsync_o <= 1'b1;
        end else begin
            hsync_o <= !((h_cnt_o >= 10'(H_ACTIVE + H_FRONT - 1))
                      && (h_cnt_o < 10'(H_ACTIVE + H_FRONT + H_SYNC - 1)));
            vsync_o <= !((v_cnt_o >= 10'(V_ACTIVE + V_FRONT - 1))
                      && (v_cnt_o < 10'(V_ACTIVE + V_FRONT + V_SYNC - 1)));
        end
    end

endmodule

`default_nettype wire

// ==== hw/tile_video.sv ====
`timescale 1ns/1ps
`default_nettype none

module tile_video import memory_game_pkg::*; (
    input  wire [9:0] h_cnt_i,
    input  wire [9:0] v_cnt_i,
    input  wire       active_i,
    input  wire rgb_t tile_color_i [NUM_TILES],
    output logic [3:0] vga_r_o,
    output logic [3:0] vga_g_o,
    output logic [3:0] vga_b_o
);

    logic [1:0] col;
    logic [1:0] row;
    tile_idx_t  tile_sel;
    rgb_t       pixel;

    assign col = 2'(h_cnt_i / TILE_W);
    assign row = 2'(v_cnt_i / TILE_H);

    // row * 4 + col
    assign tile_sel = {row, col};

    // Blanking outside the visible area
    assign pixel = active_i ? tile_color_i[tile_sel] : '0;

    assign vga_r_o = pixel[11:8];
    assign vga_g_o = pixel[7:4];
    assign vga_b_o = pixel[3:0];

endmodule

`default_nettype wire

// ==== hw/memory_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module memory_game_top import memory_game_pkg::*; #(
    parameter int H_ACTIVE     = memory_game_pkg::H_ACTIVE,
    parameter int H_FRONT      = memory_game_pkg::H_FRONT,
    parameter int H_SYNC       = memory_game_pkg::H_SYNC,
    parameter int H_TOTAL      = memory_game_pkg::H_TOTAL,
    parameter int V_ACTIVE     = memory_game_pkg::V_ACTIVE,
    parameter int V_FRONT      = memory_game_pkg::V_FRONT,
    parameter int V_SYNC       = memory_game_pkg::V_SYNC,
    parameter int V_TOTAL      = memory_game_pkg::V_TOTAL,
    parameter int DEBOUNCE_LEN = memory_game_pkg::DEBOUNCE_LEN
) (
    input  wire             clk,
    input  wire             rst,
    input  wire             start_i,
    input  wire             hint_i,
    input  wire             key_req_i,
    input  wire scan_code_t key_code_i,
    output wire             key_ack_o,
    output wire [3:0]       vga_r_o,
    output wire [3:0]       vga_g_o,
    output wire [3:0]       vga_b_o,
    output wire             hsync_o,
    output wire             vsync_o,
    output wire             pass_o
);

    logic start_press;
    logic hint_press;

    logic      tile_evt;
    tile_idx_t tile;
    logic      shift_evt;
    logic      enter_evt;

    logic                 tile_reset;
    logic                 reveal_all;
    logic                 hide_unmatched;
    logic [NUM_TILES-1:0] reveal;
    logic [NUM_TILES-1:0] toggle_flip;
    logic [NUM_TILES-1:0] set_matched;
    logic [NUM_TILES-1:0] flip;
    logic [NUM_TILES-1:0] matched;
    rgb_t                 tile_color [NUM_TILES];

    logic [9:0] h_cnt;
    logic [9:0] v_cnt;
    logic       active;

    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) i_start_btn (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (start_i),
        .press_o (start_press)
    );

    button_pulse #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) i_hint_btn (
        .clk     (clk),
        .rst     (rst),
        .btn_i   (hint_i),
        .press_o (hint_press)
    );

    key_receiver i_key_rx (
        .clk         (clk),
        .rst         (rst),
        .req_i       (key_req_i),
        .code_i      (key_code_i),
        .ack_o       (key_ack_o),
        .tile_evt_o  (tile_evt),
        .tile_o      (tile),
        .shift_evt_o (shift_evt),
        .enter_evt_o (enter_evt)
    );

    game_control i_ctrl (
        .clk              (clk),
        .rst              (rst),
        .start_i          (start_press),
        .hint_i           (hint_press),
        .tile_evt_i       (tile_evt),
        .tile_i           (tile),
        .shift_evt_i      (shift_evt),
        .enter_evt_i      (enter_evt),
        .flip_i           (flip),
        .matched_i        (matched),
        .tile_reset_o     (tile_reset),
        .reveal_all_o     (reveal_all),
        .hide_unmatched_o (hide_unmatched),
        .reveal_o         (reveal),
        .toggle_flip_o    (toggle_flip),
        .set_matched_o    (set_matched),
        .pass_o           (pass_o)
    );

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        tile_cell #(.TILE_ID(i)) i_tile (
            .clk              (clk),
            .rst              (rst),
            .tile_reset_i     (tile_reset),
            .reveal_all_i     (reveal_all),
            .hide_unmatched_i (hide_unmatched),
            .reveal_i         (reveal[i]),
            .toggle_flip_i    (toggle_flip[i]),
            .set_matched_i    (set_matched[i]),
            .flip_o           (flip[i]),
            .matched_o        (matched[i]),
            .color_o          (tile_color[i])
        );
    end

    vga_timing #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_TOTAL  (H_TOTAL),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_TOTAL  (V_TOTAL)
    ) i_timing (
        .clk      (clk),
        .rst      (rst),
        .h_cnt_o  (h_cnt),
        .v_cnt_o  (v_cnt),
        .active_o (active),
        .hsync_o  (hsync_o),
        .vsync_o  (vsync_o)
    );

    tile_video i_video (
        .h_cnt_i      (h_cnt),
        .v_cnt_i      (v_cnt),
        .active_i     (active),
        .tile_color_i (tile_color),
        .vga_r_o      (vga_r_o),
        .vga_g_o      (vga_g_o),
        .vga_b_o      (vga_b_o)
    );

endmodule

`default_nettype wire

// ==== sim/game_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_checker import memory_game_pkg::*; (
    input  wire       clk,
    input  wire       rst,
    input  wire       check_en_i,
    input  wire       start_i,
    input  wire       hint_i,
    input  wire       key_req_i,
    input  wire       key_ack_i,
    input  wire [7:0] key_code_i,
    input  wire [3:0] vga_r_i,
    input  wire [3:0] vga_g_i,
    input  wire [3:0] vga_b_i,
    input  wire       hsync_i,
    input  wire       vsync_i,
    input  wire       pass_i,
    output int        errors_o,
    output int        checks_o
);

    // Sync low windows on the previous cycle's position
    localparam int HS_FIRST = 655;
    localparam int HS_LAST  = 750;
    localparam int VS_FIRST = 489;
    localparam int VS_LAST  = 490;

    game_state_t          state;
    logic [NUM_TILES-1:0] shown;
    logic [NUM_TILES-1:0] flip;
    logic [NUM_TILES-1:0] matched;
    logic                 pend_valid;
    int                   pend_tile;
    logic                 armed;
    int                   match_cnt;
    logic                 start_q;
    logic                 hint_q;
    logic                 ack_q;
    logic                 req_q1;
    logic                 req_q2;
    int                   h_pos;
    int                   v_pos;
    int                   h_prev;
    int                   v_prev;
    logic                 exp_hsync;
    logic                 exp_vsync;
    logic                 exp_pass;

    initial begin
        errors_o = 0;
        checks_o = 0;
    end

    function automatic rgb_t expected_pixel(input int x, input int y,
                                            input logic [NUM_TILES-1:0] vis);
        int   t;
        rgb_t c;
        c = '0;
        if (x < H_ACTIVE && y < V_ACTIVE) begin
            t = (y / TILE_H) * 4 + x / TILE_W;
            if (vis[t]) begin
                c = PALETTE[t % NUM_IMAGES];
            end
        end
        return c;
    endfunction

    task automatic clear_tiles();
        shown      = '0;
        flip       = INIT_FLIP_MASK;
        matched    = '0;
        pend_valid = 1'b0;
        armed      = 1'b0;
        match_cnt  = 0;
    endtask

    task automatic apply_start();
        case (state)
            INIT: begin
                state = SHOW;
                shown = '1;
            end
            SHOW: begin
                state = GAME;
                clear_tiles();
            end
            FINISH: begin
                state = INIT;
                clear_tiles();
            end
            default: begin
            end
        endcase
    endtask

    task automatic apply_key(input logic [7:0] code);
        int t;
        t = -1;
        for (int i = 0; i < NUM_TILES; i++) begin
            if (code == TILE_KEYS[i]) begin
                t = i;
            end
        end
        if (state != GAME) begin
            return;
        end
        if (code == KEY_SHIFT) begin
            armed = 1'b1;
        end else if (code == KEY_ENTER) begin
            shown = shown & matched;
        end else if (t >= 0) begin
            shown[t] = 1'b1;
            if (armed) begin
                flip[t] = !flip[t];
                armed   = 1'b0;
            end else if (!pend_valid) begin
                pend_tile  = t;
                pend_valid = 1'b1;
            end else begin
                pend_valid = 1'b0;
                // Match needs distinct open tiles of one image and equal flip
                if (t != pend_tile && (t % NUM_IMAGES) == (pend_tile % NUM_IMAGES)
                    && flip[t] == flip[pend_tile] && !matched[t] && !matched[pend_tile]) begin
                    matched[t]         = 1'b1;
                    matched[pend_tile] = 1'b1;
                    match_cnt++;
                    if (match_cnt == PAIRS_TO_WIN) begin
                        state = FINISH;
                        shown = '1;
                    end
                end
            end
        end
    endtask

    task automatic compare(input string name, input logic [11:0] got, input logic [11:0] exp);
        checks_o++;
        if (got !== exp) begin
            if (errors_o < 20) begin
                $display("ERR %s: got %03h, expected %03h at pixel %0d,%0d",
                         name, got, exp, h_pos, v_pos);
            end
            errors_o++;
        end
    endtask

    // Model and raster position follow the rising edge
    always @(posedge clk) begin
        if (rst) begin
            state   = INIT;
            clear_tiles();
            start_q = 1'b0;
            hint_q  = 1'b0;
            ack_q   = 1'b0;
            req_q1  = 1'b0;
            req_q2  = 1'b0;
            h_pos   = 0;
            v_pos   = 0;
            h_prev  = 0;
            v_prev  = 0;
        end else begin
            if (start_i && !start_q) begin
                apply_start();
            end
            if (hint_i && !hint_q && state == GAME) begin
                shown = '1;
            end
            if (key_ack_i && !ack_q) begin
                apply_key(key_code_i);
            end
            start_q = start_i;
            hint_q  = hint_i;
            ack_q   = key_ack_i;
            req_q2  = req_q1;
            req_q1  = key_req_i;
            h_prev  = h_pos;
            v_prev  = v_pos;
            if (h_pos == H_TOTAL - 1) begin
                h_pos = 0;
                v_pos = (v_pos == V_TOTAL - 1) ? 0 : v_pos + 1;
            end else begin
                h_pos = h_pos + 1;
            end
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            // Ack follows req two cycles late
            compare("key_ack_o", {11'b0, key_ack_i}, {11'b0, req_q2});
        end
        if (check_en_i) begin
            exp_hsync = !(h_prev >= HS_FIRST && h_prev <= HS_LAST);
            exp_vsync = !(v_prev >= VS_FIRST && v_prev <= VS_LAST);
            exp_pass  = (state == FINISH);
            compare("vga_rgb", {vga_r_i, vga_g_i, vga_b_i}, expected_pixel(h_pos, v_pos, shown));
            compare("hsync_o", {11'b0, hsync_i}, {11'b0, exp_hsync});
            compare("vsync_o", {11'b0, vsync_i}, {11'b0, exp_vsync});
            compare("pass_o", {11'b0, pass_i}, {11'b0, exp_pass});
        end
    end

endmodule

`default_nettype wire

// ==== sim/tb_memory_game.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_memory_game import memory_game_pkg::*; ();

    localparam int HOLD_CYCLES  = 12;
    localparam int GAP_CYCLES   = 20;
    localparam int WAIT_LIMIT   = 200;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;

    logic        clk = 1'b0;
    logic        rst;
    logic        start;
    logic        hint;
    logic        key_req;
    scan_code_t  key_code;
    logic        key_ack;
    logic [3:0]  vga_r;
    logic [3:0]  vga_g;
    logic [3:0]  vga_b;
    logic        hsync;
    logic        vsync;
    logic        pass;
    logic        check_en;
    int          errors;
    int          checks;
    int          timeouts;
    logic [31:0] seed;
    int          order [PAIRS_TO_WIN - 1];

    always #20 clk = !clk;

    memory_game_top #(.DEBOUNCE_LEN(DEBOUNCE_LEN)) i_dut (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .hint_i     (hint),
        .key_req_i  (key_req),
        .key_code_i (key_code),
        .key_ack_o  (key_ack),
        .vga_r_o    (vga_r),
        .vga_g_o    (vga_g),
        .vga_b_o    (vga_b),
        .hsync_o    (hsync),
        .vsync_o    (vsync),
        .pass_o     (pass)
    );

    game_checker i_checker (
        .clk        (clk),
        .rst        (rst),
        .check_en_i (check_en),
        .start_i    (start),
        .hint_i     (hint),
        .key_req_i  (key_req),
        .key_ack_i  (key_ack),
        .key_code_i (key_code),
        .vga_r_i    (vga_r),
        .vga_g_i    (vga_g),
        .vga_b_i    (vga_b),
        .hsync_i    (hsync),
        .vsync_i    (vsync),
        .pass_i     (pass),
        .errors_o   (errors),
        .checks_o   (checks)
    );

    function automatic logic [31:0] next_random(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw_random(output int r, input int n);
        seed = next_random(seed);
        r    = int'(seed[30:16]) % n;
    endtask

    task automatic end_run();
        $display("Summary: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    endtask

    task automatic wait_for_ack(input logic level);
        int n;
        n = 0;
        while (key_ack !== level && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (key_ack !== level) begin
            $display("Timeout: key_ack_o did not reach %0b within %0d cycles", level, WAIT_LIMIT);
            timeouts++;
            end_run();
        end
    endtask

    // Four-phase transaction with the code set a cycle ahead of req
    task automatic send_key(input scan_code_t code);
        wait_for_ack(1'b0);
        key_code <= code;
        @(negedge clk);
        key_req <= 1'b1;
        wait_for_ack(1'b1);
        key_req <= 1'b0;
        wait_for_ack(1'b0);
    endtask

    task automatic press_button(input logic use_hint);
        if (use_hint) begin
            hint <= 1'b1;
        end else begin
            start <= 1'b1;
        end
        repeat (HOLD_CYCLES) @(negedge clk);
        start <= 1'b0;
        hint  <= 1'b0;
        repeat (GAP_CYCLES) @(negedge clk);
    endtask

    task automatic check_frame();
        check_en <= 1'b1;
        repeat (FRAME_CYCLES) @(negedge clk);
        check_en <= 1'b0;
        @(negedge clk);
    endtask

    // Second tile never shares the first tile's image
    task automatic play_wrong_pair();
        int a;
        int o;
        draw_random(a, NUM_TILES);
        draw_random(o, NUM_IMAGES - 1);
        send_key(TILE_KEYS[a]);
        send_key(TILE_KEYS[(a + o + 1) % NUM_TILES]);
    endtask

    initial begin
        int pick;
        int tmp;
        int img;
        rst      = 1'b1;
        start    = 1'b0;
        hint     = 1'b0;
        key_req  = 1'b0;
        key_code = '0;
        check_en = 1'b0;
        timeouts = 0;
        seed     = 32'h45dd_0b8d;
        repeat (10) @(negedge clk);
        rst <= 1'b0;

        check_frame();
        press_button(1'b0);
        check_frame();
        press_button(1'b0);
        check_frame();

        play_wrong_pair();
        check_frame();
        send_key(KEY_ENTER);
        check_frame();

        // Turn the pre-flipped tiles to match their partners
        for (int t = 0; t < NUM_IMAGES; t++) begin
            if (INIT_FLIP_MASK[t] != INIT_FLIP_MASK[t + NUM_IMAGES]) begin
                send_key(KEY_SHIFT);
                send_key(TILE_KEYS[t]);
            end
        end
        send_key(TILE_KEYS[0]);
        send_key(TILE_KEYS[NUM_IMAGES]);
        send_key(KEY_ENTER);
        check_frame();

        press_button(1'b1);
        check_frame();
        send_key(KEY_ENTER);

        for (int i = 0; i < PAIRS_TO_WIN - 1; i++) begin
            order[i] = i + 1;
        end
        for (int i = PAIRS_TO_WIN - 2; i > 0; i--) begin
            draw_random(pick, i + 1);
            tmp         = order[i];
            order[i]    = order[pick];
            order[pick] = tmp;
        end
        for (int i = 0; i < PAIRS_TO_WIN - 1; i++) begin
            img = order[i];
            draw_random(pick, 2);
            if (pick == 1) begin
                play_wrong_pair();
                send_key(KEY_ENTER);
            end
            draw_random(pick, 2);
            if (pick == 1) begin
                send_key(TILE_KEYS[img + NUM_IMAGES]);
                send_key(TILE_KEYS[img]);
            end else begin
                send_key(TILE_KEYS[img]);
                send_key(TILE_KEYS[img + NUM_IMAGES]);
            end
            send_key(KEY_ENTER);
        end
        check_frame();

        press_button(1'b0);
        check_frame();
        end_run();
    end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/memory_game_pkg.sv
hw/button_pulse.sv
hw/key_receiver.sv
hw/game_control.sv
hw/tile_cell.sv
hw/vga_timing.sv
hw/tile_video.sv
hw/memory_game_top.sv
sim/game_checker.sv
sim/tb_memory_game.sv

// ==== Makefile ====
TOP := tb_memory_game

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): compile.f hw/*.sv sim/*.sv
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o V$(TOP)

run: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTS PASSED"

lint:
	verilator --lint-only -Wall -f compile.f --top-module memory_game_top

clean:
	rm -rf obj_dir
